//--- verilog/ctrl_map_pkg.sv
package ctrl_map_pkg;

   localparam int NUM_CHAN = 2;
   localparam int CHAN_BITS = 1;

   // Word address map, channel c at 4*c
   localparam int REGS_PER_CHAN = 4;
   localparam int REG_OFS_W = $clog2(REGS_PER_CHAN);
   localparam logic [REG_OFS_W-1:0] REG_CMD = 2'd0;
   localparam logic [REG_OFS_W-1:0] REG_TIME_HI = 2'd1;
   localparam logic [REG_OFS_W-1:0] REG_TIME_LO = 2'd2;  // Queues the command
   localparam logic [REG_OFS_W-1:0] REG_CLEAR = 2'd3;

   localparam int WB_ADR_W = 5;
   localparam int WB_DAT_W = 32;

   // Command word fields
   localparam int CMD_SEND_IMM = 31;
   localparam int CMD_CHAIN = 30;
   localparam int CMD_LINES_W = 30;

   typedef struct packed {
      logic send_imm;
      logic chain;
      logic [CMD_LINES_W-1:0] numlines;
      logic [63:0] trig_time;  // TIME_HI:TIME_LO
   } cmd_rec_t;

   // Status byte is state code over queue occupancy
   localparam int STATE_W = 3;
   localparam int QLEN_W = 5;
   localparam int STATUS_W = STATE_W + QLEN_W;

   typedef enum logic [STATE_W-1:0] {
      ST_IDLE = 3'd0,
      ST_WAITING = 3'd1,
      ST_RUNNING = 3'd2,
      ST_OVERRUN = 3'd4,
      ST_BROKENCHAIN = 3'd5,
      ST_LATECMD = 3'd6
   } chan_state_t;

endpackage

//--- verilog/stream_pkg.sv
package stream_pkg;

   localparam int SAMPLE_W = 32;
   localparam int TIME_W = 64;
   localparam int FLAG_W = 4;

   // Flag bit positions within a record
   localparam int FLAG_OVERRUN = 3;
   localparam int FLAG_BROKENCHAIN = 2;
   localparam int FLAG_LATECMD = 1;
   localparam int FLAG_CMD_DONE = 0;

   typedef struct packed {
      logic [FLAG_W-1:0] flags;
      logic [TIME_W-1:0] rec_time;
      logic [SAMPLE_W-1:0] sample;
   } sample_rec_t;

   // Queue depths inside each channel
   localparam int CMD_DEPTH = 4;
   localparam int REC_DEPTH = 4;

endpackage

//--- verilog/short_fifo.sv
`timescale 1ns/100ps

module short_fifo
  #(parameter type payload_t = logic [31:0],
    parameter int depth = 4)
   (input  logic clk,
    input  logic arst_n_i,
    input  logic clear_i,
    input  logic push_i,
    input  payload_t data_i,
    output logic full_o,
    input  logic pop_i,
    output payload_t data_o,
    output logic empty_o,
    output logic [$clog2(depth+1)-1:0] level_o);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int lvl_w = $clog2(depth + 1);

   payload_t mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [lvl_w-1:0] count;
   logic do_push;
   logic do_pop;

   assign full_o = (count == lvl_w'(depth));
   assign empty_o = (count == '0);
   assign level_o = count;
   assign do_push = push_i & ~full_o;  // Push while full is dropped
   assign do_pop = pop_i & ~empty_o;
   assign data_o = mem[rd_ptr];  // Head falls through

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else if (clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
      pop_i |-> !empty_o);

   a_level_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
      count <= lvl_w'(depth));

endmodule

//--- verilog/ctrl_regs.sv
`timescale 1ns/100ps

module ctrl_regs
   (input  logic clk,
    input  logic arst_n_i,
    input  logic wb_cyc_i,
    input  logic wb_stb_i,
    input  logic wb_we_i,
    input  logic [ctrl_map_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  logic [ctrl_map_pkg::WB_DAT_W-1:0] wb_dat_i,
    output logic [ctrl_map_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic wb_ack_o,
    output logic [ctrl_map_pkg::NUM_CHAN-1:0] cmd_push_o,
    output ctrl_map_pkg::cmd_rec_t cmd_rec_o [ctrl_map_pkg::NUM_CHAN],
    output logic [ctrl_map_pkg::NUM_CHAN-1:0] chan_clear_o,
    input  logic [ctrl_map_pkg::STATUS_W-1:0] status_i [ctrl_map_pkg::NUM_CHAN]);

   import ctrl_map_pkg::*;

   logic wb_hit;
   logic wr_hit;
   logic chan_ok;
   logic [REG_OFS_W-1:0] ofs;
   logic [CHAN_BITS-1:0] chan;
   logic [WB_DAT_W-1:0] cmd_word [NUM_CHAN];
   logic [WB_DAT_W-1:0] time_hi [NUM_CHAN];

   assign wb_hit = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign ofs = wb_adr_i[REG_OFS_W-1:0];
   assign chan = wb_adr_i[REG_OFS_W +: CHAN_BITS];
   assign chan_ok = (wb_adr_i[WB_ADR_W-1:REG_OFS_W] < (WB_ADR_W-REG_OFS_W)'(NUM_CHAN));
   assign wr_hit = wb_hit & wb_we_i & chan_ok;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wb_ack_o <= 1'b0;
         cmd_push_o <= '0;
         chan_clear_o <= '0;
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            cmd_word[c] <= '0;
            time_hi[c] <= '0;
         end
      end
      else
      begin
         wb_ack_o <= wb_hit;
         cmd_push_o <= '0;  // Single-cycle pulses
         chan_clear_o <= '0;
         if (wr_hit)
            case (ofs)
               REG_CMD:     cmd_word[chan] <= wb_dat_i;
               REG_TIME_HI: time_hi[chan] <= wb_dat_i;
               REG_TIME_LO: cmd_push_o[chan] <= 1'b1;
               REG_CLEAR:   chan_clear_o[chan] <= 1'b1;
               default: ;
            endcase
      end
   end

   // Record and read data load on the ack edge
   always_ff @(posedge clk)
   begin
      if (wr_hit && ofs == REG_TIME_LO)
      begin
         cmd_rec_o[chan].send_imm <= cmd_word[chan][CMD_SEND_IMM];
         cmd_rec_o[chan].chain <= cmd_word[chan][CMD_CHAIN];
         cmd_rec_o[chan].numlines <= cmd_word[chan][CMD_LINES_W-1:0];
         cmd_rec_o[chan].trig_time <= {time_hi[chan], wb_dat_i};
      end
      if (wb_hit && !wb_we_i)
         wb_dat_o <= (chan_ok && ofs == REG_CMD) ? WB_DAT_W'(status_i[chan]) : '0;
   end

   a_ack_single: assert property (@(posedge clk) disable iff (!arst_n_i)
      wb_ack_o |=> !wb_ack_o);

endmodule

//--- verilog/rx_chan_ctrl.sv
`timescale 1ns/100ps

module rx_chan_ctrl
   (input  logic clk,
    input  logic arst_n_i,
    input  logic cmd_push_i,
    input  ctrl_map_pkg::cmd_rec_t cmd_rec_i,
    input  logic clear_i,
    input  logic [stream_pkg::TIME_W-1:0] vita_time_i,
    input  logic strobe_i,
    input  logic [stream_pkg::SAMPLE_W-1:0] sample_i,
    output logic run_o,
    output logic [ctrl_map_pkg::STATUS_W-1:0] status_o,
    output logic rec_valid_o,
    output stream_pkg::sample_rec_t rec_data_o,
    input  logic rec_ready_i);

   import ctrl_map_pkg::*;
   import stream_pkg::*;

   chan_state_t state;
   cmd_rec_t cmd_head;
   logic cmd_empty;
   logic cmd_pop;
   logic [$clog2(CMD_DEPTH+1)-1:0] cmd_level;
   logic [CMD_LINES_W-1:0] lines_left;
   logic [TIME_W-1:0] trig_time;
   logic send_imm;
   logic chain;
   sample_rec_t rec_in;
   logic rec_push;
   logic rec_full;
   logic rec_empty;
   logic err_state;
   logic now;
   logic late;
   logic last_line;
   logic cmd_done;

   short_fifo #(.payload_t(cmd_rec_t), .depth(CMD_DEPTH)) cmd_fifo
     (.clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_i),
      .push_i(cmd_push_i), .data_i(cmd_rec_i), .full_o(),
      .pop_i(cmd_pop), .data_o(cmd_head), .empty_o(cmd_empty), .level_o(cmd_level));

   short_fifo #(.payload_t(sample_rec_t), .depth(REC_DEPTH)) rec_fifo
     (.clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_i),
      .push_i(rec_push), .data_i(rec_in), .full_o(rec_full),
      .pop_i(rec_ready_i & rec_valid_o), .data_o(rec_data_o), .empty_o(rec_empty),
      .level_o());

   assign now = (vita_time_i == trig_time);
   assign late = (vita_time_i > trig_time);
   assign last_line = (lines_left == CMD_LINES_W'(1));
   assign run_o = (state == ST_RUNNING);
   assign err_state = state inside {ST_OVERRUN, ST_BROKENCHAIN, ST_LATECMD};

   // Done unless a chained successor carries on
   assign cmd_done = run_o & last_line & (~chain | (~cmd_empty & (cmd_head.numlines == '0)));

   assign cmd_pop = ~cmd_empty &
                    ((state == ST_IDLE) | (run_o & strobe_i & ~rec_full & last_line & chain));

   assign rec_push = (run_o & strobe_i) | err_state;  // Error record waits for space
   assign rec_valid_o = ~rec_empty;
   assign status_o = {state, QLEN_W'(cmd_level)};

   always_comb
   begin
      rec_in.flags = '0;
      rec_in.flags[FLAG_OVERRUN] = (state == ST_OVERRUN);
      rec_in.flags[FLAG_BROKENCHAIN] = (state == ST_BROKENCHAIN);
      rec_in.flags[FLAG_LATECMD] = (state == ST_LATECMD);
      rec_in.flags[FLAG_CMD_DONE] = cmd_done;
      rec_in.rec_time = vita_time_i;
      rec_in.sample = run_o ? sample_i : '0;
   end

   always_ff @(posedge clk)
   begin
      if (cmd_pop)
      begin
         trig_time <= cmd_head.trig_time;
         send_imm <= cmd_head.send_imm;
         chain <= cmd_head.chain;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state <= ST_IDLE;
         lines_left <= '0;
      end
      else if (clear_i)
      begin
         state <= ST_IDLE;
         lines_left <= '0;
      end
      else
         case (state)
            ST_IDLE:
               if (!cmd_empty && cmd_head.numlines != '0)  // Zero lines is a no-op
               begin
                  lines_left <= cmd_head.numlines;
                  state <= ST_WAITING;
               end
            ST_WAITING:
               if (send_imm || now)
                  state <= ST_RUNNING;
               else if (late)
                  state <= ST_LATECMD;
            ST_RUNNING:
               if (strobe_i)
               begin
                  if (rec_full)
                     state <= ST_OVERRUN;
                  else if (!last_line)
                     lines_left <= lines_left - 1'b1;
                  else if (!chain)
                  begin
                     lines_left <= '0;
                     state <= ST_IDLE;
                  end
                  else if (cmd_empty)
                  begin
                     lines_left <= '0;
                     state <= ST_BROKENCHAIN;
                  end
                  else
                  begin
                     lines_left <= cmd_head.numlines;  // Chained load, no wait
                     if (cmd_head.numlines == '0)
                        state <= ST_IDLE;
                  end
               end
            default:
               if (!rec_full)
                  state <= ST_IDLE;
         endcase
   end

   a_run_lines: assert property (@(posedge clk) disable iff (!arst_n_i)
      state == ST_RUNNING |-> lines_left != '0);

endmodule

//--- verilog/sample_merge.sv
`timescale 1ns/100ps

module sample_merge
   (input  logic clk,
    input  logic arst_n_i,
    input  logic [ctrl_map_pkg::NUM_CHAN-1:0] rec_valid_i,
    input  stream_pkg::sample_rec_t rec_data_i [ctrl_map_pkg::NUM_CHAN],
    output logic [ctrl_map_pkg::NUM_CHAN-1:0] rec_ready_o,
    output logic out_valid_o,
    input  logic out_ready_i,
    output logic [ctrl_map_pkg::CHAN_BITS-1:0] out_chan_o,
    output logic [stream_pkg::FLAG_W-1:0] out_flags_o,
    output logic [stream_pkg::TIME_W-1:0] out_time_o,
    output logic [stream_pkg::SAMPLE_W-1:0] out_sample_o);

   import ctrl_map_pkg::*;
   import stream_pkg::*;

   logic load;
   logic grant_ok;
   logic [CHAN_BITS-1:0] grant;
   logic [CHAN_BITS-1:0] rr_ptr;

   assign load = ~out_valid_o | out_ready_i;  // Output stage empty or draining

   // First valid channel at or after the pointer
   always_comb
   begin
      int c;
      grant = rr_ptr;
      grant_ok = 1'b0;
      rec_ready_o = '0;
      for (int i = NUM_CHAN - 1; i >= 0; i--)
      begin
         c = (int'(rr_ptr) + i) % NUM_CHAN;
         if (rec_valid_i[c])
         begin
            grant = CHAN_BITS'(c);
            grant_ok = 1'b1;
         end
      end
      if (grant_ok && load)
         rec_ready_o[grant] = 1'b1;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         out_valid_o <= 1'b0;
         rr_ptr <= '0;
      end
      else if (load)
      begin
         out_valid_o <= grant_ok;
         if (grant_ok)
            rr_ptr <= CHAN_BITS'((int'(grant) + 1) % NUM_CHAN);
      end
   end

   always_ff @(posedge clk)
   begin
      if (load && grant_ok)
      begin
         out_chan_o <= grant;
         out_flags_o <= rec_data_i[grant].flags;
         out_time_o <= rec_data_i[grant].rec_time;
         out_sample_o <= rec_data_i[grant].sample;
      end
   end

   a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o &&
      $stable({out_chan_o, out_flags_o, out_time_o, out_sample_o}));

endmodule

//--- verilog/rx_ctrl_top.sv
`timescale 1ns/100ps

module rx_ctrl_top
   (input  logic clk,
    input  logic arst_n_i,
    input  logic wb_cyc_i,
    input  logic wb_stb_i,
    input  logic wb_we_i,
    input  logic [ctrl_map_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  logic [ctrl_map_pkg::WB_DAT_W-1:0] wb_dat_i,
    output logic [ctrl_map_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic wb_ack_o,
    input  logic [stream_pkg::TIME_W-1:0] vita_time_i,
    input  logic strobe_i,
    input  logic [stream_pkg::SAMPLE_W-1:0] sample_i [ctrl_map_pkg::NUM_CHAN],
    output logic [ctrl_map_pkg::NUM_CHAN-1:0] run_o,
    output logic out_valid_o,
    input  logic out_ready_i,
    output logic [ctrl_map_pkg::CHAN_BITS-1:0] out_chan_o,
    output logic [stream_pkg::FLAG_W-1:0] out_flags_o,
    output logic [stream_pkg::TIME_W-1:0] out_time_o,
    output logic [stream_pkg::SAMPLE_W-1:0] out_sample_o);

   import ctrl_map_pkg::*;
   import stream_pkg::*;

   logic [NUM_CHAN-1:0] cmd_push;
   logic [NUM_CHAN-1:0] chan_clear;
   logic [NUM_CHAN-1:0] rec_valid;
   logic [NUM_CHAN-1:0] rec_ready;
   cmd_rec_t cmd_rec [NUM_CHAN];
   logic [STATUS_W-1:0] status [NUM_CHAN];
   sample_rec_t rec_data [NUM_CHAN];

   ctrl_regs regs0
     (.clk(clk), .arst_n_i(arst_n_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .cmd_push_o(cmd_push), .cmd_rec_o(cmd_rec), .chan_clear_o(chan_clear),
      .status_i(status));

   for (genvar c = 0; c < NUM_CHAN; c++)
   begin : g_chan
      rx_chan_ctrl chan0
        (.clk(clk), .arst_n_i(arst_n_i),
         .cmd_push_i(cmd_push[c]), .cmd_rec_i(cmd_rec[c]), .clear_i(chan_clear[c]),
         .vita_time_i(vita_time_i), .strobe_i(strobe_i), .sample_i(sample_i[c]),
         .run_o(run_o[c]), .status_o(status[c]),
         .rec_valid_o(rec_valid[c]), .rec_data_o(rec_data[c]), .rec_ready_i(rec_ready[c]));
   end

   sample_merge merge0
     (.clk(clk), .arst_n_i(arst_n_i),
      .rec_valid_i(rec_valid), .rec_data_i(rec_data), .rec_ready_o(rec_ready),
      .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .out_chan_o(out_chan_o),
      .out_flags_o(out_flags_o), .out_time_o(out_time_o), .out_sample_o(out_sample_o));

endmodule

//--- bench/tb_rx_ctrl.sv
`timescale 1ns/100ps

module tb_rx_ctrl;

   import ctrl_map_pkg::*;
   import stream_pkg::*;

   localparam int WAIT_LIMIT = 400;

   logic clk;
   logic arst_n_i;
   logic wb_cyc_i;
   logic wb_stb_i;
   logic wb_we_i;
   logic [WB_ADR_W-1:0] wb_adr_i;
   logic [WB_DAT_W-1:0] wb_dat_i;
   logic [WB_DAT_W-1:0] wb_dat_o;
   logic wb_ack_o;
   logic [TIME_W-1:0] vita_time_i;
   logic strobe_i;
   logic [SAMPLE_W-1:0] sample_i [NUM_CHAN];
   logic [NUM_CHAN-1:0] run_o;
   logic out_valid_o;
   logic out_ready_i;
   logic [CHAN_BITS-1:0] out_chan_o;
   logic [FLAG_W-1:0] out_flags_o;
   logic [TIME_W-1:0] out_time_o;
   logic [SAMPLE_W-1:0] out_sample_o;

   integer seed = 32'h7e32;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   bit timed_out = 0;
   logic [1:0] strobe_mode = 2'd0;  // 0 off, 1 on, 2 random
   logic ready_mode = 1'b1;

   // Strobes taken while running, and records seen at the output
   sample_rec_t strobe_log [$];
   logic [CHAN_BITS-1:0] strobe_chan [$];
   sample_rec_t rx_rec [$];
   logic [CHAN_BITS-1:0] rx_chan [$];

   logic [NUM_CHAN-1:0] run_prev = '0;
   logic [NUM_CHAN-1:0] trig_armed = '0;
   logic [TIME_W-1:0] trig [NUM_CHAN];
   logic [TIME_W-1:0] err_floor [NUM_CHAN];  // Flag records come later than this
   logic [WB_DAT_W-1:0] cmd_word [NUM_CHAN];
   logic [WB_DAT_W-1:0] time_hi [NUM_CHAN];

   rx_ctrl_top dut0
     (.clk(clk), .arst_n_i(arst_n_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .vita_time_i(vita_time_i), .strobe_i(strobe_i), .sample_i(sample_i), .run_o(run_o),
      .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .out_chan_o(out_chan_o),
      .out_flags_o(out_flags_o), .out_time_o(out_time_o), .out_sample_o(out_sample_o));

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   // Time, samples, strobe and ready
   always @(posedge clk)
   begin
      vita_time_i <= arst_n_i ? vita_time_i + 1'b1 : '0;
      for (int c = 0; c < NUM_CHAN; c++)
         sample_i[c] <= {1'(c), vita_time_i[SAMPLE_W-2:0]};
      case (strobe_mode)
         2'd0: strobe_i <= 1'b0;
         2'd1: strobe_i <= 1'b1;
         default: strobe_i <= 1'($random(seed));
      endcase
      out_ready_i <= ready_mode;
   end

   // Mid-cycle monitor, all DUT signals settled here
   always @(negedge clk)
   begin
      sample_rec_t r;
      if (arst_n_i)
      begin
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            if (strobe_i && run_o[c])
            begin
               r.flags = '0;
               r.rec_time = vita_time_i;
               r.sample = sample_i[c];
               strobe_log.push_back(r);
               strobe_chan.push_back(CHAN_BITS'(c));
            end
            if (run_o[c])
               err_floor[c] = vita_time_i;
            if (run_o[c] && !run_prev[c] && trig_armed[c])
            begin
               check_start(c, trig[c] + 1'b1, vita_time_i);
               trig_armed[c] = 1'b0;
            end
         end
         run_prev = run_o;
         if (out_valid_o && out_ready_i)
         begin
            r.flags = out_flags_o;
            r.rec_time = out_time_o;
            r.sample = out_sample_o;
            rx_rec.push_back(r);
            rx_chan.push_back(out_chan_o);
         end
      end
   end

   task automatic check_start(input int c, input logic [TIME_W-1:0] exp_time,
                              input logic [TIME_W-1:0] got_time);
      checks++;
      if (got_time !== exp_time)
      begin
         errors++;
         $display("FAILED at %0t: chan %0d started at time %0h, expected %0h",
                  $time, c, got_time, exp_time);
      end
   endtask

   task automatic check_rec(input logic [CHAN_BITS-1:0] exp_chan, input sample_rec_t exp_rec,
                            input logic [TIME_W-1:0] time_max,
                            input logic [CHAN_BITS-1:0] got_chan, input sample_rec_t got_rec);
      checks++;
      if (got_chan !== exp_chan || got_rec.flags !== exp_rec.flags ||
          got_rec.sample !== exp_rec.sample || $isunknown(got_rec.rec_time) ||
          got_rec.rec_time < exp_rec.rec_time || got_rec.rec_time > time_max)
      begin
         errors++;
         $display("FAILED at %0t: record chan %0d %h, expected chan %0d %h up to time %h",
                  $time, got_chan, got_rec, exp_chan, exp_rec, time_max);
      end
   endtask

   task automatic check_status(input logic [STATUS_W-1:0] exp_st,
                               input logic [STATUS_W-1:0] got_st);
      checks++;
      if (got_st !== exp_st)
      begin
         errors++;
         $display("FAILED at %0t: status %h, expected %h", $time, got_st, exp_st);
      end
   endtask

   task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] dat, output logic [WB_DAT_W-1:0] rd);
      int n;
      n = 0;
      rd = '0;
      @(posedge clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i <= we;
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (!wb_ack_o && n < WAIT_LIMIT);
      if (!wb_ack_o)
      begin
         $display("Timeout: no Wishbone ack for address %0h", adr);
         timed_out = 1'b1;
      end
      rd = wb_dat_o;
      @(posedge clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
   endtask

   task automatic expect_rec(input logic [CHAN_BITS-1:0] ch, input logic [FLAG_W-1:0] flags);
      int n;
      int idx;
      bit flag_rec;
      sample_rec_t got;
      sample_rec_t exp_rec;
      logic [CHAN_BITS-1:0] got_chan;
      logic [TIME_W-1:0] time_max;
      n = 0;
      idx = -1;
      flag_rec = (flags[FLAG_OVERRUN:FLAG_LATECMD] != '0);
      while (idx < 0 && n < WAIT_LIMIT)
      begin
         @(posedge clk);
         n++;
         // Sample records are found by the channel bit in their sample
         foreach (rx_rec[i])
            if (idx < 0 && (flag_rec ? rx_chan[i] == ch :
                            rx_rec[i].flags[FLAG_OVERRUN:FLAG_LATECMD] == '0 &&
                            rx_rec[i].sample[SAMPLE_W-1] == ch))
               idx = i;
      end
      if (idx < 0)
      begin
         $display("Timeout: no record arrived on channel %0d", ch);
         timed_out = 1'b1;
         return;
      end
      got = rx_rec[idx];
      got_chan = rx_chan[idx];
      rx_rec.delete(idx);
      rx_chan.delete(idx);
      exp_rec.flags = flags;
      if (!flag_rec)
      begin
         idx = -1;
         foreach (strobe_chan[i])
            if (idx < 0 && strobe_chan[i] == ch)
               idx = i;
         if (idx < 0)
         begin
            errors++;
            $display("Sample record on channel %0d without a logged strobe", ch);
            return;
         end
         exp_rec.rec_time = strobe_log[idx].rec_time;
         exp_rec.sample = strobe_log[idx].sample;
         time_max = exp_rec.rec_time;
         strobe_log.delete(idx);
         strobe_chan.delete(idx);
      end
      else
      begin
         // Written after the floor, before it reached the output
         exp_rec.rec_time = err_floor[ch] + 1'b1;
         exp_rec.sample = '0;
         time_max = vita_time_i - 1'b1;
         if (flags[FLAG_OVERRUN])
            for (int i = strobe_chan.size() - 1; i >= 0; i--)
               if (strobe_chan[i] == ch)
               begin
                  strobe_log.delete(i);
                  strobe_chan.delete(i);
               end
      end
      check_rec(ch, exp_rec, time_max, got_chan, got);
   endtask

   initial
   begin
      int fd;
      int code;
      string line;
      string op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] d;
      logic [WB_DAT_W-1:0] rd;
      logic [CHAN_BITS-1:0] ch;

      arst_n_i <= 1'b0;
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i <= 1'b0;
      wb_adr_i <= '0;
      wb_dat_i <= '0;
      vita_time_i <= '0;
      strobe_i <= 1'b0;
      out_ready_i <= 1'b1;
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         sample_i[c] <= '0;
         cmd_word[c] = '0;
         time_hi[c] = '0;
         err_floor[c] = '0;
      end
      repeat (16) @(posedge clk);
      arst_n_i <= 1'b1;
      repeat (2) @(posedge clk);

      fd = $fopen("bench/tb_rx_ctrl_input.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the stimulus file");
         timed_out = 1'b1;
      end
      while (fd != 0 && !timed_out && !$feof(fd))
      begin
         code = $fgets(line, fd);
         if (code == 0 || line.len() < 2 || line[0] == "#")
            continue;
         code = $sscanf(line, "%s %h %h %h", op, a, b, d);
         ch = CHAN_BITS'(a >> REG_OFS_W);
         case (op)
            "W":
            begin
               if (a[REG_OFS_W-1:0] == REG_CMD)
                  cmd_word[ch] = b;
               else if (a[REG_OFS_W-1:0] == REG_TIME_HI)
                  time_hi[ch] = b;
               else if (a[REG_OFS_W-1:0] == REG_TIME_LO)
               begin
                  trig[ch] = {time_hi[ch], b};
                  trig_armed[ch] = !cmd_word[ch][CMD_SEND_IMM];
                  err_floor[ch] = trig_armed[ch] ? trig[ch] : vita_time_i;
               end
               wb_access(1'b1, WB_ADR_W'(a), b, rd);
            end
            "R":
            begin
               wb_access(1'b0, WB_ADR_W'(a), '0, rd);
               check_status(STATUS_W'(b), rd[STATUS_W-1:0]);
            end
            "C":
            begin
               @(negedge clk);  // Modes change away from the driving edge
               strobe_mode = b[1:0];
               ready_mode = d[0];
               repeat (a) @(posedge clk);
            end
            "E": expect_rec(CHAN_BITS'(a), FLAG_W'(b));
            "P":
            begin
               tests++;
               $display("Test %0d done, %0d errors so far", a, errors);
            end
            default:
            begin
               errors++;
               $display("Unknown operation %s in stimulus file", op);
            end
         endcase
      end
      if (fd != 0)
         $fclose(fd);
      if (rx_rec.size() != 0)
      begin
         errors++;
         $display("%0d records arrived that no line expected", rx_rec.size());
      end
      if (strobe_log.size() != 0)
      begin
         errors++;
         $display("%0d logged strobes never came out as records", strobe_log.size());
      end
      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0 && !timed_out)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

//--- bench/tb_rx_ctrl_input.txt
# W addr data | R addr status | C cycles strobe ready | E chan flags | P test
# All numbers hex; strobe 0 off, 1 on, 2 random
W 0 80000003
W 1 0
W 2 0
C 28 1 1
E 0 0
E 0 0
E 0 1
R 0 00
P 1
W 0 00000002
W 1 0
W 2 300
C 300 1 1
E 0 0
E 0 1
R 0 00
P 2
W 0 00000001
W 1 0
W 2 10
C 10 1 1
E 0 2
R 0 00
P 3
C 1 0 1
W 0 C0000002
W 1 0
W 2 0
W 0 80000002
W 2 0
C 20 1 1
E 0 0
E 0 0
E 0 0
E 0 1
C 1 0 1
W 0 C0000001
W 2 0
C 10 1 1
E 0 0
E 0 4
R 0 00
P 4
C 1 0 0
W 0 80000010
W 1 0
W 2 0
C 20 1 0
C 1 0 1
E 0 0
E 0 0
E 0 0
E 0 0
E 0 0
E 0 8
W 3 0
R 0 00
P 5
C 1 0 1
W 0 80000003
W 1 0
W 4 80000003
W 5 0
W 2 0
W 6 0
C 40 2 1
E 0 0
E 0 0
E 0 1
E 1 0
E 1 0
E 1 1
R 0 00
R 4 00
P 6

//--- files.f
verilog/ctrl_map_pkg.sv
verilog/stream_pkg.sv
verilog/short_fifo.sv
verilog/ctrl_regs.sv
verilog/rx_chan_ctrl.sv
verilog/sample_merge.sv
verilog/rx_ctrl_top.sv
bench/tb_rx_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_rx_ctrl
RTL_TOP ?= rx_ctrl_top
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
